/* design/mips_word_pkg.sv */
// datapath width types for the execute and memory stages
// byte addresses are 32 bits; memory is addressed by word, lanes pick bytes

package mips_word_pkg;

   // data word, also used as a byte address
   typedef logic [31:0] word_t;

   // word-granular memory address, byte address bits 31:2
   typedef logic [29:0] word_addr_t;

   // immediate field of the instruction
   typedef logic [15:0] half_t;

   // register file index
   typedef logic [4:0] reg_idx_t;

   // byte offset inside a word, byte address bits 1:0
   typedef logic [1:0] lane_t;

   // per-byte write mask
   // bit n enables lane n, which is data bits 8n+7 down to 8n
   typedef logic [3:0] byte_en_t;

endpackage

/* design/mips_op_pkg.sv */
// ALU and memory operation encodings
// unlisted encodings give a zero ALU result and no memory access

package mips_op_pkg;

   // alu operation select
   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      // immediate shifts, op1 shifted by op2[10:6]
      alu_sll  = 4'd2,
      alu_srl  = 4'd3,
      alu_sra  = 4'd4,
      // variable shifts, op2 shifted by op1[4:0]
      alu_sllv = 4'd5,
      alu_srlv = 4'd6,
      alu_srav = 4'd7,
      alu_and  = 4'd8,
      alu_or   = 4'd9,
      alu_xor  = 4'd10,
      alu_nor  = 4'd11,
      // set-less-than, result is 1 or 0
      alu_slt  = 4'd12,
      alu_sltu = 4'd13
   } alu_op_t;

   // memory stage operation
   typedef enum logic [3:0] {
      mem_none = 4'd0,
      mem_lb   = 4'd1,
      mem_lh   = 4'd2,
      mem_lw   = 4'd3,
      mem_lbu  = 4'd4,
      mem_lhu  = 4'd5,
      mem_lui  = 4'd6,
      mem_sb   = 4'd7,
      mem_sh   = 4'd8,
      mem_sw   = 4'd9
   } mem_op_t;

endpackage

/* design/alu_unit.sv */
// execute stage: combinational ALU feeding the execute-to-memory register
// only m_valid is reset; the payload loads on issue and holds otherwise

module alu_unit (
   input  logic                    clk,
   input  logic                    rst_b,
   input  logic                    issue,
   input  mips_op_pkg::alu_op_t    alu_sel,
   input  mips_word_pkg::word_t    op1,
   input  mips_word_pkg::word_t    op2,
   input  mips_word_pkg::word_t    store_val,
   input  mips_op_pkg::mem_op_t    mem_op,
   input  mips_word_pkg::half_t    imm,
   input  mips_word_pkg::reg_idx_t dest,
   output logic                    m_valid,
   output mips_op_pkg::mem_op_t    m_op,
   output mips_word_pkg::word_t    m_result,
   output mips_word_pkg::word_t    m_store_val,
   output mips_word_pkg::half_t    m_imm,
   output mips_word_pkg::reg_idx_t m_dest
);
   import mips_word_pkg::*;
   import mips_op_pkg::*;

   word_t      alu_out;
   logic [4:0] sh_imm;
   logic [4:0] sh_var;

   // shamt field sits in op2[10:6] for the immediate forms
   assign sh_imm = op2[10:6];
   // variable shifts take the amount from the low bits of op1
   assign sh_var = op1[4:0];

   always_comb begin
      case (alu_sel)
         alu_add:  alu_out = op1 + op2;
         alu_sub:  alu_out = op1 - op2;
         alu_sll:  alu_out = op1 << sh_imm;
         alu_srl:  alu_out = op1 >> sh_imm;
         // arithmetic shift keeps the sign bit
         alu_sra:  alu_out = word_t'($signed(op1) >>> sh_imm);
         alu_sllv: alu_out = op2 << sh_var;
         alu_srlv: alu_out = op2 >> sh_var;
         alu_srav: alu_out = word_t'($signed(op2) >>> sh_var);
         alu_and:  alu_out = op1 & op2;
         alu_or:   alu_out = op1 | op2;
         alu_xor:  alu_out = op1 ^ op2;
         alu_nor:  alu_out = ~(op1 | op2);
         // compares produce a single bit, zero-extended
         alu_slt:  alu_out = {31'b0, $signed(op1) < $signed(op2)};
         alu_sltu: alu_out = {31'b0, op1 < op2};
         default:  alu_out = '0;
      endcase
   end

   // valid bit of the memory stage
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         m_valid <= 1'b0;
      end else begin
         m_valid <= issue;
      end
   end

   // memory stage payload, captured with the strobe
   always_ff @(posedge clk) begin
      if (issue) begin
         m_op        <= mem_op;
         m_result    <= alu_out;
         m_store_val <= store_val;
         m_imm       <= imm;
         m_dest      <= dest;
      end
   end

endmodule

/* design/store_align.sv */
// memory stage address split, store lane placement and load read strobe
// halfword stores assume an even lane; misaligned addresses are not flagged

module store_align (
   input  logic                      m_valid,
   input  mips_op_pkg::mem_op_t      m_op,
   input  mips_word_pkg::word_t      m_result,
   input  mips_word_pkg::word_t      m_store_val,
   output mips_word_pkg::word_addr_t mem_addr,
   output mips_word_pkg::word_t      mem_wdata,
   output mips_word_pkg::byte_en_t   mem_we,
   output logic                      mem_rd
);
   import mips_word_pkg::*;
   import mips_op_pkg::*;

   lane_t lane;

   // word address goes straight to memory, low bits select the lane
   assign mem_addr = m_result[31:2];
   assign lane     = m_result[1:0];

   always_comb begin
      mem_we    = '0;
      mem_wdata = '0;
      mem_rd    = 1'b0;
      if (m_valid) begin
         case (m_op)
            // one lane, byte moved up to it
            mem_sb: begin
               mem_we    = byte_en_t'(4'b0001 << lane);
               mem_wdata = {24'b0, m_store_val[7:0]} << {lane, 3'b000};
            end
            // two adjacent lanes starting at the offset
            mem_sh: begin
               mem_we    = byte_en_t'(4'b0011 << lane);
               mem_wdata = {16'b0, m_store_val[15:0]} << {lane, 3'b000};
            end
            mem_sw: begin
               mem_we    = 4'b1111;
               mem_wdata = m_store_val;
            end
            mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu: mem_rd = 1'b1;
            default: mem_rd = 1'b0;
         endcase
      end
   end

endmodule

/* design/load_align.sv */
// load data extraction from the memory word returned in the same cycle
// lw ignores the lane since word accesses are taken as aligned
// lui needs no memory data and only uses the immediate

module load_align (
   input  mips_op_pkg::mem_op_t  m_op,
   input  mips_word_pkg::lane_t  lane,
   input  mips_word_pkg::half_t  m_imm,
   input  mips_word_pkg::word_t  mem_rdata,
   output mips_word_pkg::word_t  load_val
);
   import mips_word_pkg::*;
   import mips_op_pkg::*;

   word_t lane_word;

   // bring the addressed lane down to bit 0
   assign lane_word = mem_rdata >> {lane, 3'b000};

   always_comb begin
      case (m_op)
         // signed forms replicate the top bit of the field
         mem_lb:  load_val = {{24{lane_word[7]}}, lane_word[7:0]};
         mem_lh:  load_val = {{16{lane_word[15]}}, lane_word[15:0]};
         mem_lbu: load_val = {24'b0, lane_word[7:0]};
         mem_lhu: load_val = {16'b0, lane_word[15:0]};
         mem_lw:  load_val = mem_rdata;
         // immediate into the upper half, low half cleared
         mem_lui: load_val = {m_imm, 16'h0000};
         default: load_val = '0;
      endcase
   end

endmodule

/* design/writeback_stage.sv */
// write-back select and register, one-cycle strobe per writing operation
// stores produce no write-back; wb_dest and wb_data hold between strobes

module writeback_stage (
   input  logic                    clk,
   input  logic                    rst_b,
   input  logic                    m_valid,
   input  mips_op_pkg::mem_op_t    m_op,
   input  mips_word_pkg::word_t    m_result,
   input  mips_word_pkg::word_t    load_val,
   input  mips_word_pkg::reg_idx_t m_dest,
   output logic                    wb_valid,
   output mips_word_pkg::reg_idx_t wb_dest,
   output mips_word_pkg::word_t    wb_data
);
   import mips_word_pkg::*;
   import mips_op_pkg::*;

   logic  wb_take;
   word_t wb_next;

   always_comb begin
      wb_take = m_valid;
      wb_next = m_result;
      case (m_op)
         // stores never write a register
         mem_sb, mem_sh, mem_sw: wb_take = 1'b0;
         // loads and lui take the aligned value
         mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu, mem_lui: wb_next = load_val;
         default: wb_next = m_result;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= wb_take;
      end
   end

   // payload only moves when a write-back is taken
   always_ff @(posedge clk) begin
      if (wb_take) begin
         wb_dest <= m_dest;
         wb_data <= wb_next;
      end
   end

endmodule

/* design/exec_mem_top.sv */
// execute and memory-access pipeline, write-back two edges after issue
// memory answers mem_rdata combinationally and writes at the clock edge
// no back-pressure; one operation per stage

module exec_mem_top (
   input  logic                      clk,
   input  logic                      rst_b,
   // issue side
   input  logic                      issue,
   input  mips_op_pkg::alu_op_t      alu_sel,
   input  mips_word_pkg::word_t      op1,
   input  mips_word_pkg::word_t      op2,
   input  mips_op_pkg::mem_op_t      mem_op,
   input  mips_word_pkg::word_t      store_val,
   input  mips_word_pkg::half_t      imm,
   input  mips_word_pkg::reg_idx_t   dest,
   // memory port
   output mips_word_pkg::word_addr_t mem_addr,
   output mips_word_pkg::word_t      mem_wdata,
   output mips_word_pkg::byte_en_t   mem_we,
   output logic                      mem_rd,
   input  mips_word_pkg::word_t      mem_rdata,
   // write-back
   output logic                      wb_valid,
   output mips_word_pkg::reg_idx_t   wb_dest,
   output mips_word_pkg::word_t      wb_data
);
   import mips_word_pkg::*;
   import mips_op_pkg::*;

   // memory stage bundle
   logic     m_valid;
   mem_op_t  m_op;
   word_t    m_result;
   word_t    m_store_val;
   half_t    m_imm;
   reg_idx_t m_dest;

   lane_t    m_lane;
   word_t    load_val;

   // byte offset of the access, shared by load alignment
   assign m_lane = m_result[1:0];

   alu_unit alu_i (
      .clk         (clk),
      .rst_b       (rst_b),
      .issue       (issue),
      .alu_sel     (alu_sel),
      .op1         (op1),
      .op2         (op2),
      .store_val   (store_val),
      .mem_op      (mem_op),
      .imm         (imm),
      .dest        (dest),
      .m_valid     (m_valid),
      .m_op        (m_op),
      .m_result    (m_result),
      .m_store_val (m_store_val),
      .m_imm       (m_imm),
      .m_dest      (m_dest)
   );

   store_align store_i (
      .m_valid     (m_valid),
      .m_op        (m_op),
      .m_result    (m_result),
      .m_store_val (m_store_val),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .mem_we      (mem_we),
      .mem_rd      (mem_rd)
   );

   load_align load_i (
      .m_op      (m_op),
      .lane      (m_lane),
      .m_imm     (m_imm),
      .mem_rdata (mem_rdata),
      .load_val  (load_val)
   );

   writeback_stage wb_i (
      .clk      (clk),
      .rst_b    (rst_b),
      .m_valid  (m_valid),
      .m_op     (m_op),
      .m_result (m_result),
      .load_val (load_val),
      .m_dest   (m_dest),
      .wb_valid (wb_valid),
      .wb_dest  (wb_dest),
      .wb_data  (wb_data)
   );

endmodule

/* tests/tb_checks.svh */
// compare tasks and expected-value helpers for the exec/mem testbench
// included inside the testbench module after its package imports

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic stop_with_failure();
   $display("Something failed");
   $fatal(1);
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
   if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
   end
endtask

task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
   if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
   end
endtask

task automatic check_mask(input string name, input byte_en_t got, input byte_en_t exp);
   if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
   end
endtask

task automatic check_addr(input string name, input word_addr_t got, input word_addr_t exp);
   if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
   end
endtask

// lanes a store touches, from the access size and the byte offset
function automatic byte_en_t lane_mask(input mem_op_t mop, input lane_t lane);
   byte_en_t m;
   m = '0;
   for (int n = 0; n < 4; n++) begin
      if (mop == mem_sw) m[n] = 1'b1;
      if (mop == mem_sb && n == int'(lane)) m[n] = 1'b1;
      if (mop == mem_sh && (n == int'(lane) || n == int'(lane) + 1)) m[n] = 1'b1;
   end
   return m;
endfunction

// memory word after enabled lanes take the new bytes
function automatic word_t merge_lanes(input word_t old, input word_t data, input byte_en_t m);
   word_t r;
   r = old;
   for (int n = 0; n < 4; n++) begin
      if (m[n]) r[n*8 +: 8] = data[n*8 +: 8];
   end
   return r;
endfunction

// arithmetic right shift built from a logical shift and a sign fill
function automatic word_t sra_ref(input word_t v, input logic [4:0] s);
   word_t r;
   r = v >> s;
   if (v[31]) r = r | ~(32'hffffffff >> s);
   return r;
endfunction

`endif

/* tests/tb_exec_mem.sv */
// directed testbench for the execute and memory-access pipeline
// 64-word memory model, only byte address bits 7:2 select a word

module tb_exec_mem;
   import mips_word_pkg::*;
   import mips_op_pkg::*;

   logic clk = 1'b0;
   logic rst_b;
   logic issue;
   alu_op_t alu_sel;
   mem_op_t mem_op;
   word_t op1, op2, store_val, mem_rdata, mem_wdata, wb_data;
   half_t imm;
   reg_idx_t dest, wb_dest;
   word_addr_t mem_addr, seen_addr;
   byte_en_t mem_we, seen_we;
   logic mem_rd, wb_valid, seen_rd;
   word_t seen_wdata;
   word_t mem_model [64];
   // expected memory contents, kept by the tests alone
   word_t shadow [64];
   int cycles = 0;

   `include "tb_checks.svh"

   exec_mem_top dut_i (
      .clk(clk), .rst_b(rst_b), .issue(issue), .alu_sel(alu_sel), .op1(op1), .op2(op2),
      .mem_op(mem_op), .store_val(store_val), .imm(imm), .dest(dest),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_rd(mem_rd),
      .mem_rdata(mem_rdata), .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
   );

   always #2 clk = ~clk;

   // combinational read, byte-masked write at the edge
   assign mem_rdata = mem_model[mem_addr[5:0]];
   always @(posedge clk) begin
      for (int n = 0; n < 4; n++) begin
         if (mem_we[n]) mem_model[mem_addr[5:0]][n*8 +: 8] <= mem_wdata[n*8 +: 8];
      end
   end

   // tests take about 150 cycles, limit leaves ample margin
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= 400) begin
         $display("timeout: the run went past 400 clock cycles");
         stop_with_failure();
      end
   end

   task automatic drive_op(input alu_op_t sel, input word_t a, input word_t b,
                           input mem_op_t mop, input word_t sv, input half_t im,
                           input reg_idx_t d);
      issue = 1'b1;
      alu_sel = sel;
      op1 = a;
      op2 = b;
      mem_op = mop;
      store_val = sv;
      imm = im;
      dest = d;
   endtask

   // one operation alone; starts and ends 1 unit after a rising edge
   task automatic single_op(input alu_op_t sel, input word_t a, input word_t b,
                            input mem_op_t mop, input word_t sv, input half_t im,
                            input reg_idx_t d, input logic exp_wb, input word_t exp_data);
      drive_op(sel, a, b, mop, sv, im, d);
      @(posedge clk);
      #1 issue = 1'b0;
      // memory cycle
      @(negedge clk);
      seen_addr = mem_addr;
      seen_we = mem_we;
      seen_wdata = mem_wdata;
      seen_rd = mem_rd;
      @(posedge clk);
      @(negedge clk);
      check_flag("wb_valid", wb_valid, exp_wb);
      if (exp_wb) begin
         check_reg("wb_dest", wb_dest, d);
         check_word("wb_data", wb_data, exp_data);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic idle_after_reset();
      repeat (5) begin
         @(negedge clk);
         check_flag("wb_valid", wb_valid, 1'b0);
         check_mask("mem_we", mem_we, 4'h0);
         check_flag("mem_rd", mem_rd, 1'b0);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic alu_logic_ops();
      alu_op_t ops [6];
      word_t a, b, e;
      ops = '{alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor};
      for (int i = 0; i < 6; i++) begin
         a = $urandom;
         b = $urandom;
         case (ops[i])
            alu_add: e = a + b;
            alu_sub: e = a + ~b + 32'd1;
            alu_and: e = a & b;
            alu_or:  e = a | b;
            alu_xor: e = a ^ b;
            default: e = ~a & ~b;
         endcase
         single_op(ops[i], a, b, mem_none, 32'h0, 16'h0, reg_idx_t'(i + 1), 1'b1, e);
      end
   endtask

   task automatic shifts_compares();
      word_t a, b;
      a = $urandom;
      b = $urandom;
      single_op(alu_sll, a, b, mem_none, 0, 0, 5'd7, 1'b1, a << b[10:6]);
      single_op(alu_srl, a, b, mem_none, 0, 0, 5'd8, 1'b1, a >> b[10:6]);
      // force a negative op1 so the sign fill shows
      a[31] = 1'b1;
      single_op(alu_sra, a, b, mem_none, 0, 0, 5'd9, 1'b1, sra_ref(a, b[10:6]));
      b[31] = 1'b1;
      single_op(alu_sllv, a, b, mem_none, 0, 0, 5'd10, 1'b1, b << a[4:0]);
      single_op(alu_srlv, a, b, mem_none, 0, 0, 5'd11, 1'b1, b >> a[4:0]);
      single_op(alu_srav, a, b, mem_none, 0, 0, 5'd12, 1'b1, sra_ref(b, a[4:0]));
      // -16 against 5: signed and unsigned order disagree
      single_op(alu_slt, 32'hfffffff0, 32'd5, mem_none, 0, 0, 5'd13, 1'b1, 32'd1);
      single_op(alu_sltu, 32'hfffffff0, 32'd5, mem_none, 0, 0, 5'd14, 1'b1, 32'd0);
      single_op(alu_slt, 32'd5, 32'hfffffff0, mem_none, 0, 0, 5'd15, 1'b1, 32'd0);
      single_op(alu_sltu, 32'd5, 32'hfffffff0, mem_none, 0, 0, 5'd16, 1'b1, 32'd1);
   endtask

   task automatic store_check(input mem_op_t mop, input int w, input lane_t lane);
      word_t v, lanes, exp_data;
      byte_en_t m;
      v = $urandom;
      m = lane_mask(mop, lane);
      exp_data = (mop == mem_sw) ? v : (v << (8 * int'(lane)));
      lanes = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
      single_op(alu_add, word_t'(w * 4), word_t'(lane), mop, v, 0, 5'd20, 1'b0, 0);
      check_addr("mem_addr", seen_addr, word_addr_t'(w));
      check_mask("mem_we", seen_we, m);
      check_word("mem_wdata", seen_wdata & lanes, exp_data & lanes);
      check_flag("mem_rd", seen_rd, 1'b0);
      shadow[w] = merge_lanes(shadow[w], exp_data, m);
      check_word("memory word", mem_model[w], shadow[w]);
   endtask

   task automatic load_check(input mem_op_t mop, input int w, input lane_t lane);
      word_t s, e;
      s = shadow[w] >> (8 * int'(lane));
      case (mop)
         mem_lb:  e = {{24{s[7]}}, s[7:0]};
         mem_lbu: e = {24'h0, s[7:0]};
         mem_lh:  e = {{16{s[15]}}, s[15:0]};
         mem_lhu: e = {16'h0, s[15:0]};
         default: e = shadow[w];
      endcase
      single_op(alu_add, word_t'(w * 4), word_t'(lane), mop, 0, 0, 5'd21, 1'b1, e);
      check_addr("mem_addr", seen_addr, word_addr_t'(w));
      check_flag("mem_rd", seen_rd, 1'b1);
   endtask

   task automatic stores_and_loads();
      for (int l = 0; l < 4; l++) store_check(mem_sb, 8, lane_t'(l));
      store_check(mem_sh, 9, 2'd0);
      store_check(mem_sh, 9, 2'd2);
      store_check(mem_sw, 10, 2'd0);
      for (int l = 0; l < 4; l++) begin
         load_check(mem_lb, 8, lane_t'(l));
         load_check(mem_lbu, 8, lane_t'(l));
      end
      load_check(mem_lh, 9, 2'd2);
      load_check(mem_lhu, 9, 2'd0);
      load_check(mem_lw, 10, 2'd0);
      single_op(alu_add, 0, 0, mem_lui, 0, 16'h9abc, 5'd22, 1'b1, 32'h9abc0000);
   endtask

   // five back-to-back operations, each write-back two edges after its issue
   task automatic back_to_back();
      logic exp_v [5];
      word_t exp_d [5];
      word_t a, b, v;
      a = $urandom;
      b = $urandom;
      v = $urandom;
      exp_v = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1};
      exp_d = '{a + b, 32'h0, v, {24'h0, v[15:8]}, a ^ b};
      for (int e = 0; e < 7; e++) begin
         case (e)
            0: drive_op(alu_add, a, b, mem_none, 0, 0, 5'd1);
            1: drive_op(alu_add, 32'd48, 32'd0, mem_sw, v, 0, 5'd2);
            2: drive_op(alu_add, 32'd48, 32'd0, mem_lw, 0, 0, 5'd3);
            3: drive_op(alu_add, 32'd48, 32'd1, mem_lbu, 0, 0, 5'd4);
            4: drive_op(alu_xor, a, b, mem_none, 0, 0, 5'd5);
            default: issue = 1'b0;
         endcase
         @(negedge clk);
         if (e >= 2) begin
            check_flag("wb_valid", wb_valid, exp_v[e-2]);
            if (exp_v[e-2]) begin
               check_reg("wb_dest", wb_dest, reg_idx_t'(e - 1));
               check_word("wb_data", wb_data, exp_d[e-2]);
            end
         end
         @(posedge clk);
         #1;
      end
      shadow[12] = v;
      check_word("memory word", mem_model[12], shadow[12]);
   endtask

   initial begin
      void'($urandom(35364));
      for (int i = 0; i < 64; i++) begin
         mem_model[i] <= 32'h13572468 ^ (i * 32'h01030507);
         shadow[i] = 32'h13572468 ^ (i * 32'h01030507);
      end
      rst_b = 1'b0;
      drive_op(alu_add, 0, 0, mem_none, 0, 0, 0);
      issue = 1'b0;
      repeat (3) @(posedge clk);
      #1 rst_b = 1'b1;
      idle_after_reset();
      alu_logic_ops();
      shifts_compares();
      stores_and_loads();
      back_to_back();
      $display("Everything OK");
      $finish;
   end

endmodule

/* list.f */
+incdir+tests
design/mips_word_pkg.sv
design/mips_op_pkg.sv
design/alu_unit.sv
design/store_align.sv
design/load_align.sv
design/writeback_stage.sv
design/exec_mem_top.sv
tests/tb_exec_mem.sv

/* run.sh */
#!/bin/sh
# compile and run the exec/mem testbench with Verilator
# a failing check ends the simulation with $fatal, giving a non-zero status
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
   --top-module tb_exec_mem \
   -f list.f \
   -o sim_exec_mem

./obj_dir/sim_exec_mem
